//--- hdl/cpuPkg.sv
package cpuPkg;

	localparam int dataWidth = 16;
	localparam int regCount = 4;
	localparam logic [dataWidth-1:0] resetVector = '0;

	typedef enum logic [3:0] {
		opAdd = 4'h0,
		opSub = 4'h1,
		opAnd = 4'h2,
		opOr  = 4'h3,
		opXor = 4'h4,
		opLdi = 4'h5,
		opLd  = 4'h6,
		opSt  = 4'h7,
		opJmp = 4'h8,
		opJz  = 4'h9,
		opNop = 4'hF
	} opcodeT;

	typedef enum logic [1:0] {
		FETCH   = 2'd0,
		DECODE  = 2'd1,
		EXECUTE = 2'd2,
		COMMIT  = 2'd3
	} phaseT;

	typedef enum logic [2:0] {
		aluAdd   = 3'd0,
		aluSub   = 3'd1,
		aluAnd   = 3'd2,
		aluOr    = 3'd3,
		aluXor   = 3'd4,
		aluPassB = 3'd5
	} aluOpT;

	// single instruction format, msb first
	typedef struct packed {
		opcodeT opcode;
		logic [1:0] rd;
		logic [1:0] rs;
		logic [7:0] imm;
	} instrT;

	typedef struct packed {
		opcodeT opcode;
		logic [1:0] rd;
		logic [1:0] rs;
		logic [7:0] imm;
		logic useImm;
		logic memRead;
		logic memWrite;
		logic regWrite;
		logic jump;
		logic jumpIfZero;
		logic needBus;
	} ctrlT;

endpackage

//--- hdl/busPkg.sv
package busPkg;

	localparam int adrWidth = 16;
	localparam int datWidth = 16;

	// wishbone classic, master side
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [adrWidth-1:0] adr;
		logic [datWidth-1:0] datW;
	} wbMasterT;

	// slave response
	typedef struct packed {
		logic ack;
		logic [datWidth-1:0] datR;
	} wbSlaveT;

endpackage

//--- hdl/phaseSequencer.sv
`timescale 1ns/10ps

module phaseSequencer(
	input logic CLK,
	input logic arstN,
	input logic needBus,
	input logic busDone,
	output cpuPkg::phaseT phase
);

always_ff @(posedge CLK or negedge arstN) begin
	if (!arstN) begin
		phase <= cpuPkg::FETCH;
	end else begin
		case (phase)
			cpuPkg::FETCH: begin
				// hold until the instruction word arrives
				if (busDone) begin
					phase <= cpuPkg::DECODE;
				end
			end
			cpuPkg::DECODE: begin
				phase <= cpuPkg::EXECUTE;
			end
			cpuPkg::EXECUTE: begin
				// loads and stores wait for their bus cycle
				if (!needBus || busDone) begin
					phase <= cpuPkg::COMMIT;
				end
			end
			default: begin
				phase <= cpuPkg::FETCH;
			end
		endcase
	end
end

endmodule

//--- hdl/instructionDecoder.sv
`timescale 1ns/10ps

module instructionDecoder(
	input logic CLK,
	input logic arstN,
	input cpuPkg::phaseT phase,
	input logic busDone,
	input logic [cpuPkg::dataWidth-1:0] fetchData,
	output cpuPkg::ctrlT ctrl,
	output cpuPkg::aluOpT aluOp
);

cpuPkg::instrT instr;

// instruction register, loaded as the fetch completes
always_ff @(posedge CLK or negedge arstN) begin
	if (!arstN) begin
		instr <= '{opcode: cpuPkg::opNop, rd: 2'd0, rs: 2'd0, imm: 8'd0};
	end else if (phase == cpuPkg::FETCH && busDone) begin
		instr <= cpuPkg::instrT'(fetchData);
	end
end

always_comb begin
	ctrl = '0;
	ctrl.opcode = instr.opcode;
	ctrl.rd = instr.rd;
	ctrl.rs = instr.rs;
	ctrl.imm = instr.imm;
	aluOp = cpuPkg::aluPassB;
	case (instr.opcode)
		cpuPkg::opAdd: begin
			aluOp = cpuPkg::aluAdd;
			ctrl.regWrite = 1'b1;
		end
		cpuPkg::opSub: begin
			aluOp = cpuPkg::aluSub;
			ctrl.regWrite = 1'b1;
		end
		cpuPkg::opAnd: begin
			aluOp = cpuPkg::aluAnd;
			ctrl.regWrite = 1'b1;
		end
		cpuPkg::opOr: begin
			aluOp = cpuPkg::aluOr;
			ctrl.regWrite = 1'b1;
		end
		cpuPkg::opXor: begin
			aluOp = cpuPkg::aluXor;
			ctrl.regWrite = 1'b1;
		end
		cpuPkg::opLdi: begin
			// immediate passes straight through the alu
			ctrl.useImm = 1'b1;
			ctrl.regWrite = 1'b1;
		end
		cpuPkg::opLd: begin
			ctrl.memRead = 1'b1;
			ctrl.regWrite = 1'b1;
		end
		cpuPkg::opSt: begin
			ctrl.memWrite = 1'b1;
		end
		cpuPkg::opJmp: begin
			ctrl.jump = 1'b1;
		end
		cpuPkg::opJz: begin
			ctrl.jumpIfZero = 1'b1;
		end
		default: begin
			// nop and unused encodings
			ctrl.opcode = cpuPkg::opNop;
		end
	endcase
	ctrl.needBus = ctrl.memRead | ctrl.memWrite;
end

endmodule

//--- hdl/aluUnit.sv
`timescale 1ns/10ps

module aluUnit(
	input logic CLK,
	input logic arstN,
	input cpuPkg::phaseT phase,
	input cpuPkg::aluOpT aluOp,
	input logic useImm,
	input logic [cpuPkg::dataWidth-1:0] opA,
	input logic [cpuPkg::dataWidth-1:0] opB,
	input logic [7:0] imm,
	output logic [cpuPkg::dataWidth-1:0] result,
	output logic zero
);

logic [cpuPkg::dataWidth-1:0] operandB;
logic [cpuPkg::dataWidth-1:0] aluOut;
logic flagUpdate;

assign operandB = useImm ? {{(cpuPkg::dataWidth-8){1'b0}}, imm} : opB;

always_comb begin
	case (aluOp)
		cpuPkg::aluAdd: aluOut = opA + operandB;
		cpuPkg::aluSub: aluOut = opA - operandB;
		cpuPkg::aluAnd: aluOut = opA & operandB;
		cpuPkg::aluOr: aluOut = opA | operandB;
		cpuPkg::aluXor: aluOut = opA ^ operandB;
		default: aluOut = operandB;
	endcase
end

assign flagUpdate = (phase == cpuPkg::EXECUTE) && (aluOp != cpuPkg::aluPassB);

always_ff @(posedge CLK) begin
	if (phase == cpuPkg::EXECUTE) begin
		result <= aluOut;
	end
end

// zero flag follows alu opcodes only
always_ff @(posedge CLK or negedge arstN) begin
	if (!arstN) begin
		zero <= 1'b0;
	end else if (flagUpdate) begin
		zero <= (aluOut == '0);
	end
end

endmodule

//--- hdl/registerFile.sv
`timescale 1ns/10ps

module registerFile(
	input logic CLK,
	input logic arstN,
	input cpuPkg::phaseT phase,
	input cpuPkg::ctrlT ctrl,
	input logic [cpuPkg::dataWidth-1:0] aluResult,
	input logic [cpuPkg::dataWidth-1:0] loadData,
	output logic [cpuPkg::dataWidth-1:0] rdData,
	output logic [cpuPkg::dataWidth-1:0] rsData
);

logic [cpuPkg::dataWidth-1:0] regs [cpuPkg::regCount];

assign rdData = regs[ctrl.rd];
assign rsData = regs[ctrl.rs];

always_ff @(posedge CLK or negedge arstN) begin
	if (!arstN) begin
		for (int i = 0; i < cpuPkg::regCount; i++) begin
			regs[i] <= '0;
		end
	end else if (phase == cpuPkg::COMMIT && ctrl.regWrite) begin
		// loads take the bus word, everything else the alu result
		regs[ctrl.rd] <= ctrl.memRead ? loadData : aluResult;
	end
end

endmodule

//--- hdl/programCounter.sv
`timescale 1ns/10ps

module programCounter(
	input logic CLK,
	input logic arstN,
	input cpuPkg::phaseT phase,
	input cpuPkg::ctrlT ctrl,
	input logic zero,
	output logic [cpuPkg::dataWidth-1:0] pc
);

logic takeJump;

assign takeJump = ctrl.jump || (ctrl.jumpIfZero && zero);

always_ff @(posedge CLK or negedge arstN) begin
	if (!arstN) begin
		pc <= cpuPkg::resetVector;
	end else if (phase == cpuPkg::COMMIT) begin
		if (takeJump) begin
			// absolute target, zero extended
			pc <= {{(cpuPkg::dataWidth-8){1'b0}}, ctrl.imm};
		end else begin
			pc <= pc + 1'b1;
		end
	end
end

endmodule

//--- hdl/busController.sv
`timescale 1ns/10ps

module busController(
	input logic CLK,
	input logic arstN,
	input cpuPkg::phaseT phase,
	input cpuPkg::ctrlT ctrl,
	input logic [cpuPkg::dataWidth-1:0] pc,
	input logic [cpuPkg::dataWidth-1:0] addr,
	input logic [cpuPkg::dataWidth-1:0] storeData,
	output busPkg::wbMasterT wbM,
	input busPkg::wbSlaveT wbS,
	output logic busDone,
	output logic [cpuPkg::dataWidth-1:0] loadData
);

logic cyc;
logic we;
logic [busPkg::adrWidth-1:0] adr;
logic [busPkg::datWidth-1:0] datW;

assign busDone = cyc & wbS.ack;

always_ff @(posedge CLK or negedge arstN) begin
	if (!arstN) begin
		cyc <= 1'b0;
		we <= 1'b0;
	end else if (cyc) begin
		// close in the clock after ack
		if (wbS.ack) begin
			cyc <= 1'b0;
			we <= 1'b0;
		end
	end else if (phase == cpuPkg::FETCH) begin
		cyc <= 1'b1;
		we <= 1'b0;
	end else if (phase == cpuPkg::EXECUTE && ctrl.needBus) begin
		cyc <= 1'b1;
		we <= ctrl.memWrite;
	end
end

// address and write data frozen while a cycle is open
always_ff @(posedge CLK) begin
	if (!cyc) begin
		adr <= (phase == cpuPkg::FETCH) ? pc : addr;
		datW <= storeData;
	end
end

always_ff @(posedge CLK) begin
	if (busDone) begin
		loadData <= wbS.datR;
	end
end

always_comb begin
	wbM.cyc = cyc;
	wbM.stb = cyc;
	wbM.we = we;
	wbM.adr = adr;
	wbM.datW = datW;
end

endmodule

//--- hdl/core.sv
`timescale 1ns/10ps

module core(
	input logic CLK,
	input logic arstN,
	output busPkg::wbMasterT wbM,
	input busPkg::wbSlaveT wbS,
	output cpuPkg::phaseT phase
);

cpuPkg::ctrlT ctrl;
cpuPkg::aluOpT aluOp;
logic busDone;
logic zero;
logic [cpuPkg::dataWidth-1:0] pc;
logic [cpuPkg::dataWidth-1:0] rdData;
logic [cpuPkg::dataWidth-1:0] rsData;
logic [cpuPkg::dataWidth-1:0] aluResult;
logic [cpuPkg::dataWidth-1:0] loadData;

phaseSequencer phaseSequencerInst(
	.CLK(CLK),
	.arstN(arstN),
	.needBus(ctrl.needBus),
	.busDone(busDone),
	.phase(phase)
);

// instruction word comes straight off the read bus
instructionDecoder instructionDecoderInst(
	.CLK(CLK),
	.arstN(arstN),
	.phase(phase),
	.busDone(busDone),
	.fetchData(wbS.datR),
	.ctrl(ctrl),
	.aluOp(aluOp)
);

aluUnit aluUnitInst(
	.CLK(CLK),
	.arstN(arstN),
	.phase(phase),
	.aluOp(aluOp),
	.useImm(ctrl.useImm),
	.opA(rdData),
	.opB(rsData),
	.imm(ctrl.imm),
	.result(aluResult),
	.zero(zero)
);

registerFile registerFileInst(
	.CLK(CLK),
	.arstN(arstN),
	.phase(phase),
	.ctrl(ctrl),
	.aluResult(aluResult),
	.loadData(loadData),
	.rdData(rdData),
	.rsData(rsData)
);

programCounter programCounterInst(
	.CLK(CLK),
	.arstN(arstN),
	.phase(phase),
	.ctrl(ctrl),
	.zero(zero),
	.pc(pc)
);

// rs holds the memory address, rd the store data
busController busControllerInst(
	.CLK(CLK),
	.arstN(arstN),
	.phase(phase),
	.ctrl(ctrl),
	.pc(pc),
	.addr(rsData),
	.storeData(rdData),
	.wbM(wbM),
	.wbS(wbS),
	.busDone(busDone),
	.loadData(loadData)
);

endmodule

//--- dv/coreChecker.sv
`timescale 1ns/10ps

module coreChecker(
	input logic CLK,
	input logic arstN,
	input busPkg::wbMasterT wbM,
	input busPkg::wbSlaveT wbS,
	input cpuPkg::phaseT phase,
	input logic [15:0] expStore,
	input logic jzTaken,
	input logic rowEnd,
	output int loopCount,
	output int dataErrors,
	output int protocolErrors
);

int loops = 0;
int dataErrs = 0;
int protoErrs = 0;
int storeCount = 0;
logic [15:0] expFetch;
logic [15:0] lastFetch;
logic [15:0] holdAdr;
logic holdWe;
logic holdValid;
logic [3:0] fetchedOp;

assign loopCount = loops;
assign dataErrors = dataErrs;
assign protocolErrors = protoErrs;

task automatic compareValue(input string name, input logic [15:0] got, input logic [15:0] want);
	if (got !== want) begin
		$display("mismatch at %0t: %s got %h expected %h", $time, name, got, want);
		dataErrs++;
	end
endtask

task automatic protocolError(input string what);
	$display("protocol error at %0t: %s", $time, what);
	protoErrs++;
endtask

always @(posedge CLK) begin
	if (!arstN) begin
		loops = 0;
		storeCount = 0;
		expFetch = cpuPkg::resetVector;
		lastFetch = 16'hFFFF;
		holdValid = 1'b0;
	end else begin
		if (wbM.stb && !wbM.cyc) begin
			protocolError("stb is high while cyc is low");
		end
		if (wbM.cyc && holdValid && (wbM.adr !== holdAdr || wbM.we !== holdWe)) begin
			protocolError("adr or we changed while the cycle waited for ack");
		end
		holdValid = wbM.cyc && !wbS.ack;
		holdAdr = wbM.adr;
		holdWe = wbM.we;
		if (wbM.cyc && wbS.ack) begin
			if (phase == cpuPkg::FETCH) begin
				compareValue("wbM.adr", wbM.adr, expFetch);
				if (wbM.adr == lastFetch) begin
					loops++;
				end
				lastFetch = wbM.adr;
				// next fetch follows the word just fetched
				fetchedOp = wbS.datR[15:12];
				if (fetchedOp == cpuPkg::opJmp || (fetchedOp == cpuPkg::opJz && jzTaken)) begin
					expFetch = {8'h00, wbS.datR[7:0]};
				end else begin
					expFetch = expFetch + 16'd1;
				end
			end else if (phase != cpuPkg::EXECUTE) begin
				protocolError("a bus cycle ended outside the fetch and execute phases");
			end else if (wbM.we) begin
				storeCount++;
				compareValue("wbM.adr", wbM.adr, 16'h0080);
				compareValue("wbM.datW", wbM.datW, expStore);
			end
		end
		if (rowEnd && storeCount != 1) begin
			protocolError($sformatf("expected one store in the row but saw %0d", storeCount));
		end
	end
end

endmodule

//--- dv/coreTb.sv
`timescale 1ns/10ps

module coreTb;

localparam int rowCount = 10;
localparam int cycleLimit = 200 * rowCount;

typedef struct packed {
	cpuPkg::opcodeT op;
	logic [15:0] a;
	logic [15:0] b;
	logic [15:0] expected;
} rowT;

// op, a, b, stored word
rowT rows [rowCount] = '{
	'{cpuPkg::opAdd, 16'h0012, 16'h0034, 16'h0046},
	'{cpuPkg::opAdd, 16'h00FF, 16'h00FF, 16'h01FE},
	'{cpuPkg::opSub, 16'h0050, 16'h0020, 16'h0030},
	'{cpuPkg::opSub, 16'h0001, 16'h0002, 16'hFFFF},
	'{cpuPkg::opAnd, 16'h00F0, 16'h003C, 16'h0030},
	'{cpuPkg::opOr, 16'h00F0, 16'h000F, 16'h00FF},
	'{cpuPkg::opXor, 16'h00AA, 16'h00AA, 16'h0000},
	'{cpuPkg::opLd, 16'hBEEF, 16'h0000, 16'hBEEF},
	'{cpuPkg::opJz, 16'h0033, 16'h0033, 16'h005A},
	'{cpuPkg::opJz, 16'h0033, 16'h0034, 16'hDEAD}
};

logic CLK = 1'b0;
logic arstN;
logic rowEnd;
logic jzTaken;
logic [15:0] expStore;
busPkg::wbMasterT wbM;
busPkg::wbSlaveT wbS;
cpuPkg::phaseT phase;
int loopCount;
int dataErrors;
int protocolErrors;
int cycles = 0;
int seed = 98;
int waits;
logic busy;
logic [15:0] mem [256];

always #50 CLK = ~CLK;

core UUT(
	.CLK(CLK),
	.arstN(arstN),
	.wbM(wbM),
	.wbS(wbS),
	.phase(phase)
);

coreChecker coreCheckerInst(
	.CLK(CLK),
	.arstN(arstN),
	.wbM(wbM),
	.wbS(wbS),
	.phase(phase),
	.expStore(expStore),
	.jzTaken(jzTaken),
	.rowEnd(rowEnd),
	.loopCount(loopCount),
	.dataErrors(dataErrors),
	.protocolErrors(protocolErrors)
);

function automatic logic [15:0] encode(cpuPkg::opcodeT op, logic [1:0] rd, logic [1:0] rs,
		logic [7:0] imm);
	return {op, rd, rs, imm};
endfunction

task automatic loadProgram(input rowT r);
	for (int i = 0; i < 256; i++) begin
		mem[i] = {i[7:0] ^ 8'h5A, ~i[7:0]};
	end
	case (r.op)
		cpuPkg::opLd: begin
			mem[8'h90] = r.a;
			mem[0] = encode(cpuPkg::opLdi, 2'd3, 2'd0, 8'h90);
			mem[1] = encode(cpuPkg::opLd, 2'd1, 2'd3, 8'h00);
			mem[2] = encode(cpuPkg::opLdi, 2'd3, 2'd0, 8'h80);
			mem[3] = encode(cpuPkg::opSt, 2'd1, 2'd3, 8'h00);
			mem[4] = encode(cpuPkg::opJmp, 2'd0, 2'd0, 8'd4);
		end
		cpuPkg::opJz: begin
			// taken path stores the marker 0x5a, fall through stores 0xdead
			mem[8'h91] = 16'hDEAD;
			mem[0] = encode(cpuPkg::opLdi, 2'd1, 2'd0, r.a[7:0]);
			mem[1] = encode(cpuPkg::opLdi, 2'd2, 2'd0, r.b[7:0]);
			mem[2] = encode(cpuPkg::opLdi, 2'd3, 2'd0, 8'h80);
			mem[3] = encode(cpuPkg::opSub, 2'd1, 2'd2, 8'h00);
			mem[4] = encode(cpuPkg::opJz, 2'd0, 2'd0, 8'd9);
			mem[5] = encode(cpuPkg::opLdi, 2'd0, 2'd0, 8'h91);
			mem[6] = encode(cpuPkg::opLd, 2'd1, 2'd0, 8'h00);
			mem[7] = encode(cpuPkg::opSt, 2'd1, 2'd3, 8'h00);
			mem[8] = encode(cpuPkg::opJmp, 2'd0, 2'd0, 8'd8);
			mem[9] = encode(cpuPkg::opLdi, 2'd1, 2'd0, 8'h5A);
			mem[10] = encode(cpuPkg::opSt, 2'd1, 2'd3, 8'h00);
			mem[11] = encode(cpuPkg::opJmp, 2'd0, 2'd0, 8'd11);
		end
		default: begin
			mem[0] = encode(cpuPkg::opLdi, 2'd1, 2'd0, r.a[7:0]);
			mem[1] = encode(cpuPkg::opLdi, 2'd2, 2'd0, r.b[7:0]);
			mem[2] = encode(cpuPkg::opLdi, 2'd3, 2'd0, 8'h80);
			mem[3] = encode(r.op, 2'd1, 2'd2, 8'h00);
			mem[4] = encode(cpuPkg::opSt, 2'd1, 2'd3, 8'h00);
			mem[5] = encode(cpuPkg::opJmp, 2'd0, 2'd0, 8'd5);
		end
	endcase
endtask

// wishbone slave, 0 to 3 wait states per cycle
task automatic serveBus();
	if (wbS.ack) begin
		wbS.ack = 1'b0;
		busy = 1'b0;
	end else if (wbM.cyc && wbM.stb) begin
		if (!busy) begin
			busy = 1'b1;
			waits = {$random(seed)} % 4;
		end
		if (waits == 0) begin
			wbS.ack = 1'b1;
			wbS.datR = mem[wbM.adr[7:0]];
			if (wbM.we) begin
				mem[wbM.adr[7:0]] = wbM.datW;
			end
		end else begin
			waits--;
		end
	end
endtask

always @(posedge CLK) begin
	cycles++;
	if (cycles >= cycleLimit) begin
		$display("timeout: the run did not finish within %0d cycles", cycleLimit);
		$display("Regression failed");
		$finish;
	end
end

initial begin
	arstN = 1'b0;
	wbS = '0;
	rowEnd = 1'b0;
	jzTaken = 1'b0;
	expStore = '0;
	busy = 1'b0;
	waits = 0;
	for (int r = 0; r < rowCount; r++) begin
		arstN = 1'b0;
		wbS = '0;
		busy = 1'b0;
		expStore = rows[r].expected;
		jzTaken = (rows[r].a == rows[r].b);
		loadProgram(rows[r]);
		repeat (10) @(negedge CLK);
		arstN = 1'b1;
		// run until the closing jump has fetched itself twice
		while (loopCount < 2) begin
			@(negedge CLK);
			serveBus();
		end
		rowEnd = 1'b1;
		@(negedge CLK);
		rowEnd = 1'b0;
	end
	$display("errors: data %0d, protocol %0d", dataErrors, protocolErrors);
	if (dataErrors + protocolErrors == 0) begin
		$display("Regression passed");
	end else begin
		$display("Regression failed");
	end
	$finish;
end

endmodule

//--- verilog.f
hdl/cpuPkg.sv
hdl/busPkg.sv
hdl/phaseSequencer.sv
hdl/instructionDecoder.sv
hdl/aluUnit.sv
hdl/registerFile.sv
hdl/programCounter.sv
hdl/busController.sv
hdl/core.sv
dv/coreChecker.sv
dv/coreTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= coreTb
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf $(BUILD_DIR)
